// ==== gteCompute.f ====
+incdir+include
source/gtePkg.sv
source/gteRegFile.sv
source/gteSequencer.sv
source/gteComputePath.sv
source/gteClip.sv
source/gteTop.sv
tests/gteTop_tb.sv

// ==== include/gteCompute_defs.svh ====
//----------------------------------------------------------------------------
// Register map and flag layout of the GTE compute subsystem
// Addresses 16 and up are read-only; unmapped addresses read zero
//----------------------------------------------------------------------------
`ifndef GTE_COMPUTE_DEFS_SVH
`define GTE_COMPUTE_DEFS_SVH

`define GTE_SUM_W       44      // Accumulator width
`define GTE_FRAC        12      // Fraction shift for TR and sf
`define GTE_ADDR_W      5

// Config registers, matrix row-major
`define GTE_ADDR_M11    5'd0
`define GTE_ADDR_M33    5'd8
`define GTE_ADDR_V0     5'd9
`define GTE_ADDR_V2     5'd11
`define GTE_ADDR_TR0    5'd12
`define GTE_ADDR_TR2    5'd14

// Results
`define GTE_ADDR_MAC1   5'd16
`define GTE_ADDR_MAC3   5'd18
`define GTE_ADDR_IR1    5'd19
`define GTE_ADDR_IR3    5'd21
`define GTE_ADDR_FLAG   5'd22

// Flag bits for row 1, rows 2 and 3 sit one and two bits lower
`define GTE_FLAG_POS1   30
`define GTE_FLAG_NEG1   27
`define GTE_FLAG_IRSAT1 24
`define GTE_FLAG_ERR    31

`endif

// ==== run.sh ====
#!/bin/sh
# Build the gteTop testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module gteTop_tb -f gteCompute.f -o gteTopSim

if ./obj_dir/gteTopSim | tee /dev/stderr | grep "Test completed successfully" > /dev/null; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

// ==== source/gteClip.sv ====
//----------------------------------------------------------------------------
// MAC from the 44-bit sum, then IR saturated to 16 bits, no latency
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "gteCompute_defs.svh"

module gteClip (
	input  wire [`GTE_SUM_W-1:0]  i_sum,
	input  wire                   i_ovfPos,
	input  wire                   i_ovfNeg,
	input  wire gtePkg::gteCmd    i_cmd,
	output gtePkg::gteRowResult   o_res
);
	import gtePkg::*;

	logic signed [31:0] mac;
	logic signed [31:0] irLo;
	logic [15:0]        ir;
	logic               irSat;

	// sf keeps the integer part, otherwise the low word is taken as is
	assign mac  = i_cmd.sf ? i_sum[`GTE_FRAC +: 32] : i_sum[31:0];
	assign irLo = i_cmd.lm ? 32'sd0 : -32'sd32768;

	always_comb begin
		irSat = 1'b1;
		if (mac > 32'sd32767) begin
			ir = 16'h7fff;
		end else if (mac < irLo) begin
			ir = irLo[15:0];            // 0 or 8000h
		end else begin
			ir    = mac[15:0];
			irSat = 1'b0;
		end
	end

	assign o_res = gteRowResult'{
		mac:   mac,
		ir:    ir,
		flags: gteRowFlags'{macPos: i_ovfPos, macNeg: i_ovfNeg, irSat: irSat}
	};

endmodule

`default_nettype wire

// ==== source/gteComputePath.sv ====
//----------------------------------------------------------------------------
// Zero-latency MVMVA row summing TR*4096 and three signed 16x16 products
// Partial sums wrap to 44 bits; each stage's overflow is reported
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "gteCompute_defs.svh"

module gteComputePath (
	input  wire gtePkg::gteRowOperands  i_ops,
	input  wire gtePkg::gteCmd          i_cmd,
	output logic [`GTE_SUM_W-1:0]       o_sum,
	output logic                        o_ovfPos,
	output logic                        o_ovfNeg
);
	import gtePkg::*;

	logic signed [15:0]    matLane [0:2];
	logic signed [15:0]    vecLane [0:2];
	logic signed [31:0]    prod    [0:2];
	logic [`GTE_SUM_W-1:0] trTerm;
	logic [`GTE_SUM_W-1:0] acc;         // Running sum wrapped to 44 bits
	logic [`GTE_SUM_W:0]   stage;       // One guard bit for overflow

	//------------------------------------------------------------------------
	// Product lanes
	//------------------------------------------------------------------------
	assign matLane[0] = i_ops.mat0;
	assign matLane[1] = i_ops.mat1;
	assign matLane[2] = i_ops.mat2;
	assign vecLane[0] = i_ops.vec0;
	assign vecLane[1] = i_ops.vec1;
	assign vecLane[2] = i_ops.vec2;

	for (genvar g = 0; g < 3; g++) begin : genLane
		assign prod[g] = matLane[g] * vecLane[g];   // Signed 16x16 -> 32
	end

	// TR << 12 fills the 44-bit accumulator exactly and keeps the sign on top
	assign trTerm = i_cmd.useTr ? {i_ops.tr, {`GTE_FRAC{1'b0}}} : '0;

	//------------------------------------------------------------------------
	// Chained sum with per-stage range check
	//------------------------------------------------------------------------
	always_comb begin
		acc      = trTerm;
		stage    = '0;
		o_ovfPos = 1'b0;
		o_ovfNeg = 1'b0;
		for (int i = 0; i < 3; i++) begin
			stage = {acc[`GTE_SUM_W-1], acc}
				+ {{(`GTE_SUM_W + 1 - 32){prod[i][31]}}, prod[i]};
			// Guard and top bit disagree when the 44-bit range is left
			o_ovfPos = o_ovfPos | (!stage[`GTE_SUM_W] && stage[`GTE_SUM_W-1]);
			o_ovfNeg = o_ovfNeg | (stage[`GTE_SUM_W] && !stage[`GTE_SUM_W-1]);
			acc = stage[`GTE_SUM_W-1:0];
		end
		o_sum = acc;
	end

endmodule

`default_nettype wire

// ==== source/gtePkg.sv ====
//----------------------------------------------------------------------------
// Types shared by the GTE compute blocks
// Operand fields are raw two's complement, consumers sign them
//----------------------------------------------------------------------------
`default_nettype none

`include "gteCompute_defs.svh"

package gtePkg;

	// Command latched at start
	typedef struct packed {
		logic sf;       // Shift MAC right by the fraction width
		logic lm;       // Clamp IR at zero
		logic useTr;    // Add the translation term
	} gteCmd;

	// Operands for one matrix row
	typedef struct packed {
		logic [15:0] mat0;
		logic [15:0] mat1;
		logic [15:0] mat2;
		logic [15:0] vec0;
		logic [15:0] vec1;
		logic [15:0] vec2;
		logic [31:0] tr;
	} gteRowOperands;

	typedef struct packed {
		logic macPos;   // 44-bit positive overflow
		logic macNeg;   // 44-bit negative overflow
		logic irSat;
	} gteRowFlags;

	// What one row writes back
	typedef struct packed {
		logic [31:0] mac;
		logic [15:0] ir;
		gteRowFlags  flags;
	} gteRowResult;

endpackage

`default_nettype wire

// ==== source/gteRegFile.sv ====
//----------------------------------------------------------------------------
// Config and result registers; writes are dropped while the engine is busy
// Result rows are stored on rowWr, the flag word is cleared by an accepted start
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "gteCompute_defs.svh"

module gteRegFile (
	input  wire                        i_clk,
	input  wire                        i_rstN,
	input  wire                        i_wrEn,
	input  wire [`GTE_ADDR_W-1:0]      i_wrAddr,
	input  wire [31:0]                 i_wrData,
	input  wire [`GTE_ADDR_W-1:0]      i_rdAddr,
	input  wire                        i_busy,
	input  wire                        i_start,
	input  wire [1:0]                  i_rowSel,
	input  wire                        i_rowWr,
	input  wire gtePkg::gteRowResult   i_rowRes,
	output logic [31:0]                o_rdData,
	output gtePkg::gteRowOperands      o_rowOps
);
	import gtePkg::*;

	logic [15:0] mat [0:8];
	logic [15:0] vec [0:2];
	logic [31:0] tr  [0:2];
	logic [31:0] mac [0:2];
	logic [15:0] ir  [0:2];
	logic [30:0] flagReg;           // Sticky bits, bit 31 is derived
	logic [31:0] flagWord;
	logic [30:0] rowFlagSet;
	gteRowFlags  rowFlags;
	logic [3:0]  matBase;

	// Slot of an address inside a three-entry group
	function automatic logic [1:0] slotOf(input logic [`GTE_ADDR_W-1:0] addr,
			input logic [`GTE_ADDR_W-1:0] base);
		logic [`GTE_ADDR_W-1:0] off;
		off = addr - base;
		return off[1:0];
	endfunction

	//------------------------------------------------------------------------
	// Row operand selection
	//------------------------------------------------------------------------
	assign matBase = {2'b00, i_rowSel} + {1'b0, i_rowSel, 1'b0};   // rowSel * 3

	assign o_rowOps = gteRowOperands'{
		mat0: mat[matBase],
		mat1: mat[matBase + 4'd1],
		mat2: mat[matBase + 4'd2],
		vec0: vec[0],
		vec1: vec[1],
		vec2: vec[2],
		tr:   tr[i_rowSel]
	};

	// Place the row flags at their row's bit positions
	assign rowFlags = i_rowRes.flags;
	assign rowFlagSet = ({30'd0, rowFlags.macPos} << (`GTE_FLAG_POS1 - i_rowSel))
		| ({30'd0, rowFlags.macNeg} << (`GTE_FLAG_NEG1 - i_rowSel))
		| ({30'd0, rowFlags.irSat} << (`GTE_FLAG_IRSAT1 - i_rowSel));

	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			for (int i = 0; i < 9; i++) begin
				mat[i] <= '0;
			end
			for (int i = 0; i < 3; i++) begin
				vec[i] <= '0;
				tr[i]  <= '0;
				mac[i] <= '0;
				ir[i]  <= '0;
			end
			flagReg <= '0;
		end else begin
			if (i_wrEn && !i_busy) begin
				case (i_wrAddr) inside
					[`GTE_ADDR_M11:`GTE_ADDR_M33]: mat[i_wrAddr[3:0]] <= i_wrData[15:0];
					[`GTE_ADDR_V0:`GTE_ADDR_V2]:
						vec[slotOf(i_wrAddr, `GTE_ADDR_V0)] <= i_wrData[15:0];
					[`GTE_ADDR_TR0:`GTE_ADDR_TR2]:
						tr[slotOf(i_wrAddr, `GTE_ADDR_TR0)] <= i_wrData;
					default: ;      // Read-only or unmapped
				endcase
			end
			if (i_start && !i_busy) begin
				flagReg <= '0;
			end else if (i_rowWr) begin
				mac[i_rowSel] <= i_rowRes.mac;
				ir[i_rowSel]  <= i_rowRes.ir;
				flagReg       <= flagReg | rowFlagSet;
			end
		end
	end

	//------------------------------------------------------------------------
	// Read port
	//------------------------------------------------------------------------
	always_comb begin
		flagWord = {1'b0, flagReg};
		flagWord[`GTE_FLAG_ERR] = |flagReg[`GTE_FLAG_POS1:`GTE_FLAG_IRSAT1 - 1];
		case (i_rdAddr) inside
			[`GTE_ADDR_M11:`GTE_ADDR_M33]:
				o_rdData = {{16{mat[i_rdAddr[3:0]][15]}}, mat[i_rdAddr[3:0]]};
			[`GTE_ADDR_V0:`GTE_ADDR_V2]:
				o_rdData = {{16{vec[slotOf(i_rdAddr, `GTE_ADDR_V0)][15]}},
					vec[slotOf(i_rdAddr, `GTE_ADDR_V0)]};
			[`GTE_ADDR_TR0:`GTE_ADDR_TR2]:   o_rdData = tr[slotOf(i_rdAddr, `GTE_ADDR_TR0)];
			[`GTE_ADDR_MAC1:`GTE_ADDR_MAC3]: o_rdData = mac[slotOf(i_rdAddr, `GTE_ADDR_MAC1)];
			[`GTE_ADDR_IR1:`GTE_ADDR_IR3]:
				o_rdData = {{16{ir[slotOf(i_rdAddr, `GTE_ADDR_IR1)][15]}},
					ir[slotOf(i_rdAddr, `GTE_ADDR_IR1)]};
			`GTE_ADDR_FLAG:                  o_rdData = flagWord;
			default:                         o_rdData = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/gteSequencer.sv ====
//----------------------------------------------------------------------------
// Steps rows 1..3 over three cycles after an accepted start
// Start is ignored while busy; done is a single-cycle pulse
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "gteCompute_defs.svh"

module gteSequencer (
	input  wire                 i_clk,
	input  wire                 i_rstN,
	input  wire                 i_start,
	input  wire gtePkg::gteCmd  i_cmd,
	output logic                o_busy,
	output logic                o_done,
	output logic [1:0]          o_rowSel,
	output logic                o_rowWr,
	output gtePkg::gteCmd       o_cmd
);
	import gtePkg::*;

	localparam logic [1:0] LAST_ROW = 2'd2;

	gteCmd      cmdLatch;
	logic [1:0] rowCnt;

	//------------------------------------------------------------------------
	// Row counter FSM
	//------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			o_busy   <= 1'b0;
			o_done   <= 1'b0;
			rowCnt   <= '0;
			cmdLatch <= '0;
		end else begin
			o_done <= 1'b0;             // Pulse by default
			if (!o_busy) begin
				if (i_start) begin
					o_busy   <= 1'b1;
					cmdLatch <= i_cmd;
				end
			end else if (rowCnt == LAST_ROW) begin
				// Third row is written at this edge
				o_busy <= 1'b0;
				o_done <= 1'b1;
				rowCnt <= '0;
			end else begin
				rowCnt <= rowCnt + 2'd1;
			end
		end
	end

	// Every busy cycle retires one row
	assign o_rowWr  = o_busy;
	assign o_rowSel = rowCnt;
	assign o_cmd    = cmdLatch;

endmodule

`default_nettype wire

// ==== source/gteTop.sv ====
//----------------------------------------------------------------------------
// GTE compute subsystem, one MVMVA command per start
// Results are valid from o_done on; no back-pressure
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gteTop (
	input  wire                 i_clk,
	input  wire                 i_rstN,
	input  wire                 i_wrEn,
	input  wire [4:0]           i_wrAddr,
	input  wire [31:0]          i_wrData,
	input  wire [4:0]           i_rdAddr,
	input  wire                 i_start,
	input  wire gtePkg::gteCmd  i_cmd,
	output logic [31:0]         o_rdData,
	output logic                o_busy,
	output logic                o_done
);
	import gtePkg::*;

	gteCmd         cmd;            // Latched command
	gteRowOperands rowOps;
	gteRowResult   rowRes;
	logic [1:0]    rowSel;
	logic          rowWr;
	logic [43:0]   sum;            // Accumulator width
	logic          ovfPos;
	logic          ovfNeg;

	gteSequencer uSeq (
		.i_clk    (i_clk),
		.i_rstN   (i_rstN),
		.i_start  (i_start),
		.i_cmd    (i_cmd),
		.o_busy   (o_busy),
		.o_done   (o_done),
		.o_rowSel (rowSel),
		.o_rowWr  (rowWr),
		.o_cmd    (cmd)
	);

	gteRegFile uRegs (
		.i_clk    (i_clk),
		.i_rstN   (i_rstN),
		.i_wrEn   (i_wrEn),
		.i_wrAddr (i_wrAddr),
		.i_wrData (i_wrData),
		.i_rdAddr (i_rdAddr),
		.i_busy   (o_busy),
		.i_start  (i_start),
		.i_rowSel (rowSel),
		.i_rowWr  (rowWr),
		.i_rowRes (rowRes),
		.o_rdData (o_rdData),
		.o_rowOps (rowOps)
	);

	gteComputePath uPath (
		.i_ops    (rowOps),
		.i_cmd    (cmd),
		.o_sum    (sum),
		.o_ovfPos (ovfPos),
		.o_ovfNeg (ovfNeg)
	);

	gteClip uClip (
		.i_sum    (sum),
		.i_ovfPos (ovfPos),
		.i_ovfNeg (ovfNeg),
		.i_cmd    (cmd),
		.o_res    (rowRes)
	);

endmodule

`default_nettype wire

// ==== tests/gteTop_tb.sv ====
//----------------------------------------------------------------------------
// Testbench for gteTop with fixed table cases, then xorshift random cases
// Random cases take their expected values from a wide-integer model
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "gteCompute_defs.svh"

module gteTop_tb;
	import gtePkg::*;

	localparam int DONE_TIMEOUT = 20;         // Cycles
	localparam int RANDOM_CASES = 24;
	localparam longint SUM_MAX = (64'sd1 <<< 43) - 64'sd1;
	localparam longint SUM_MIN = -(64'sd1 <<< 43);

	// One command with its operands and the values read back afterwards
	typedef struct packed {
		logic [0:8][15:0] mat;              // Row-major
		logic [0:2][15:0] vec;
		logic [0:2][31:0] tr;
		gteCmd            cmd;
		logic [0:2][31:0] expMac;
		logic [0:2][31:0] expIr;            // Sign-extended as read
		logic [31:0]      expFlag;
	} caseEntry;

	logic        clk;
	logic        rstN;
	logic        wrEn;
	logic [4:0]  wrAddr;
	logic [31:0] wrData;
	logic [4:0]  rdAddr;
	logic        start;
	gteCmd       cmd;
	logic [31:0] rdData;
	logic        busy;
	logic        done;
	caseEntry    caseTable [0:3];
	caseEntry    randCase;
	logic [31:0] rngState;
	logic [31:0] readVal;

	gteTop DUT (
		.i_clk    (clk),
		.i_rstN   (rstN),
		.i_wrEn   (wrEn),
		.i_wrAddr (wrAddr),
		.i_wrData (wrData),
		.i_rdAddr (rdAddr),
		.i_start  (start),
		.i_cmd    (cmd),
		.o_rdData (rdData),
		.o_busy   (busy),
		.o_done   (done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	//------------------------------------------------------------------------
	// Reference model with exact 64-bit sums wrapped to 44 bits
	//------------------------------------------------------------------------
	function automatic caseEntry predictResults(input caseEntry c);
		caseEntry r;
		longint   acc;
		longint   sum;
		longint   macS;
		longint   irLow;
		longint   irVal;
		logic     pos;
		logic     neg;
		logic     sat;
		r = c;
		r.expFlag = '0;
		for (int row = 0; row < 3; row++) begin
			acc = c.cmd.useTr ? longint'($signed(c.tr[row])) * 4096 : 64'sd0;
			pos = 1'b0;
			neg = 1'b0;
			for (int k = 0; k < 3; k++) begin
				sum = acc + longint'($signed(c.mat[row * 3 + k]))
					* longint'($signed(c.vec[k]));
				pos |= (sum > SUM_MAX);
				neg |= (sum < SUM_MIN);
				acc = (sum <<< 20) >>> 20;      // Back into the 44-bit range
			end
			macS = c.cmd.sf ? (acc >>> `GTE_FRAC) : longint'($signed(acc[31:0]));
			irLow = c.cmd.lm ? 64'sd0 : -64'sd32768;
			sat = 1'b1;
			if (macS > 32767) begin
				irVal = 32767;
			end else if (macS < irLow) begin
				irVal = irLow;
			end else begin
				irVal = macS;
				sat   = 1'b0;
			end
			r.expMac[row] = macS[31:0];
			r.expIr[row]  = irVal[31:0];
			r.expFlag[`GTE_FLAG_POS1 - row]   = pos;
			r.expFlag[`GTE_FLAG_NEG1 - row]   = neg;
			r.expFlag[`GTE_FLAG_IRSAT1 - row] = sat;
		end
		r.expFlag[`GTE_FLAG_ERR] = |r.expFlag[30:23];
		return r;
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic checkValue(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			abortRun($sformatf("Fail at %0d ns: %s read %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
		@(negedge clk);
		wrEn   = 1'b1;
		wrAddr = addr;
		wrData = data;
		@(posedge clk);
	endtask

	// Address on the falling edge, data taken at the next rising edge
	task automatic readReg(input logic [4:0] addr, output logic [31:0] data);
		@(negedge clk);
		rdAddr = addr;
		@(posedge clk);
		data = rdData;
	endtask

	//------------------------------------------------------------------------
	// Load, start, wait for done, read back
	//------------------------------------------------------------------------
	task automatic runCase(input caseEntry c, input string name);
		int          cycles;
		logic [31:0] val;
		for (int i = 0; i < 9; i++) begin
			writeReg(`GTE_ADDR_M11 + 5'(i), {16'd0, c.mat[i]});
		end
		for (int i = 0; i < 3; i++) begin
			writeReg(`GTE_ADDR_V0 + 5'(i), {16'd0, c.vec[i]});
			writeReg(`GTE_ADDR_TR0 + 5'(i), c.tr[i]);
		end
		@(negedge clk);
		wrEn  = 1'b0;
		start = 1'b1;
		cmd   = c.cmd;
		@(posedge clk);                     // Start accepted here
		@(negedge clk);
		checkValue({name, " busy after start"}, {31'd0, busy}, 32'd1);
		// A second start and a V0 write while busy must both be dropped
		cmd    = ~c.cmd;
		wrEn   = 1'b1;
		wrAddr = `GTE_ADDR_V0;
		wrData = {16'd0, ~c.vec[0]};
		cycles = 0;
		while (!done) begin
			@(negedge clk);
			start = 1'b0;
			wrEn  = 1'b0;
			cycles++;
			if (cycles > DONE_TIMEOUT) begin
				abortRun($sformatf("Timeout: o_done never went high in %s", name));
			end
		end
		checkValue({name, " edges from start to done"}, cycles, 32'd3);
		checkValue({name, " busy at done"}, {31'd0, busy}, 32'd0);
		@(negedge clk);
		checkValue({name, " done after one cycle"}, {31'd0, done}, 32'd0);
		checkValue({name, " busy after done"}, {31'd0, busy}, 32'd0);
		for (int row = 0; row < 3; row++) begin
			readReg(`GTE_ADDR_MAC1 + 5'(row), val);
			checkValue($sformatf("%s MAC%0d", name, row + 1), val, c.expMac[row]);
			readReg(`GTE_ADDR_IR1 + 5'(row), val);
			checkValue($sformatf("%s IR%0d", name, row + 1), val, c.expIr[row]);
		end
		readReg(`GTE_ADDR_FLAG, val);
		checkValue({name, " FLAG"}, val, c.expFlag);
		readReg(`GTE_ADDR_V0, val);
		checkValue({name, " V0 after busy write"}, val,
			{{16{c.vec[0][15]}}, c.vec[0]});
	endtask

	initial begin
		rstN     = 1'b0;
		wrEn     = 1'b0;
		wrAddr   = '0;
		wrData   = '0;
		rdAddr   = '0;
		start    = 1'b0;
		cmd      = '0;
		rngState = 32'd98163;

		// Each entry holds mat, vec, tr, cmd {sf, lm, useTr}, MAC, IR and FLAG
		// POS sits at 30..28, NEG at 27..25, IRSAT at 24..22 and ERR 31 covers 30..23
		caseTable[0] = '{{16'd1, 16'd2, 16'd3, -16'sd1, 16'd0, 16'd4, 48'd0},
			{16'd10, 16'd20, 16'd30}, {32'd0, 32'd1, 32'd8}, 3'b001,
			{32'd140, 32'd4206, 32'h8000}, {32'd140, 32'd4206, 32'h7fff}, 32'h0040_0000};
		caseTable[1] = '{{16'd4096, 48'd0, 16'd4096, 48'd0, -16'sd4096},
			{16'd5, -16'sd3, 16'd100}, {32'd2, 32'd0, 32'd0}, 3'b111,
			{32'd7, 32'hffff_fffd, 32'hffff_ff9c}, {32'd7, 32'd0, 32'd0}, 32'h80c0_0000};
		caseTable[2] = '{{16'd1, 48'd0, 16'd1, 48'd0, 16'd0},    // 44-bit overflow both ways
			{16'd5000, -16'sd5000, 16'd0}, {32'h7fff_ffff, 32'h8000_0000, 32'd0}, 3'b001,
			{32'd904, 32'hffff_ec78, 32'd0}, {32'd904, 32'hffff_ec78, 32'd0}, 32'hc400_0000};
		caseTable[3] = '{{16'd1, 16'd1, 16'd1, -16'sd1, -16'sd1, -16'sd1, 16'd2, 32'd0},
			{16'd100, 16'd200, 16'd300}, {32'h7fff_ffff, 32'd5, 32'd5}, 3'b000,
			{32'd600, 32'hffff_fda8, 32'd200}, {32'd600, 32'hffff_fda8, 32'd200}, 32'd0};

		repeat (8) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		checkValue("busy after reset", {31'd0, busy}, 32'd0);
		checkValue("done after reset", {31'd0, done}, 32'd0);
		for (int a = 0; a < 32; a++) begin
			readReg(5'(a), readVal);
			checkValue($sformatf("register %0d after reset", a), readVal, 32'd0);
		end

		for (int i = 0; i < 4; i++) begin
			runCase(caseTable[i], $sformatf("case %0d", i));
		end

		for (int n = 0; n < RANDOM_CASES; n++) begin
			rngState = xorshift(rngState);
			randCase.cmd = rngState[2:0];
			for (int i = 0; i < 9; i++) begin
				rngState = xorshift(rngState);
				// Small matrices in some cases keep IR out of saturation
				randCase.mat[i] = randCase.cmd.sf ? {{10{rngState[5]}}, rngState[5:0]}
					: rngState[31:16];
			end
			for (int i = 0; i < 3; i++) begin
				rngState = xorshift(rngState);
				randCase.vec[i] = rngState[31:16];
				rngState = xorshift(rngState);
				randCase.tr[i] = rngState[0] ? rngState
					: {{20{rngState[31]}}, rngState[31:20]};
			end
			runCase(predictResults(randCase), $sformatf("random %0d", n));
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
